// ==== sim.f ====
cpuPkg.sv
regBlock.sv
alu.sv
datapath.sv
controller.sv
cpuTop.sv
tbCpu.sv

// ==== Bender.yml ====
package:
  name: cpu_multicycle

sources:
  - cpuPkg.sv
  - regBlock.sv
  - alu.sv
  - datapath.sv
  - controller.sv
  - cpuTop.sv
  - target: simulation
    files:
      - tbCpu.sv

// ==== tbCpu.sv ====
`timescale 1ns/1ns

module tbCpu;
	import cpuPkg::*;

	localparam wordT highBase = 16'h0010;
	localparam wordT storeBase = 16'h00C0;
	localparam int haltLimit = 1000;

	logic Clock;
	logic rstN;
	logic rstHighN;
	memReqT reqLow;
	memReqT reqHigh;
	logic haltedLow;
	logic haltedHigh;
	wordT rdataLow;
	wordT rdataHigh;

	// Shared word memory with one CPU out of reset at a time
	wordT mem [256];
	wordT prog[$];
	// Constant table at 0xF0 reached through r0 with offsets -16..-1
	wordT consts [16];
	memReqT expWrites[$];
	memReqT writes[$];
	int unsigned seed;

	cpuTop #(
		.resetPc (16'h0000)
	) dut_i (
		.Clock    (Clock),
		.rstN     (rstN),
		.memRData (rdataLow),
		.memReq   (reqLow),
		.halted   (haltedLow)
	);

	// Second CPU for the nonzero reset address
	cpuTop #(
		.resetPc (highBase)
	) dutHigh_i (
		.Clock    (Clock),
		.rstN     (rstHighN),
		.memRData (rdataHigh),
		.memReq   (reqHigh),
		.halted   (haltedHigh)
	);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;
	end

	// Combinational read on the low address byte
	assign rdataLow = mem[reqLow.addr[7:0]];
	assign rdataHigh = mem[reqHigh.addr[7:0]];

	always @(posedge Clock) begin
		if (reqLow.write) begin
			mem[reqLow.addr[7:0]] <= reqLow.wData;
		end
		if (reqHigh.write) begin
			mem[reqHigh.addr[7:0]] <= reqHigh.wData;
		end
	end

	// Write log taken mid cycle
	always @(negedge Clock) begin
		if (reqLow.write) begin
			writes.push_back(reqLow);
		end
		if (reqHigh.write) begin
			writes.push_back(reqHigh);
		end
	end

	task automatic compareWord(input wordT actual, input wordT expected, input string what);
		if (actual !== expected) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("Errors found");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic compareBit(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
			$display("Errors found");
			$fatal(1, "bit mismatch");
		end
	endtask

	task automatic compareReq(input memReqT actual, input memReqT expected, input string what);
		if (actual !== expected) begin
			$display("error at %0t ns: %s is r%b w%b %h %h, expected r%b w%b %h %h", $time, what,
				actual.read, actual.write, actual.addr, actual.wData,
				expected.read, expected.write, expected.addr, expected.wData);
			$display("Errors found");
			$fatal(1, "request mismatch");
		end
	endtask

	function automatic memReqT makeReq(input logic rd, input logic wr, input wordT addr,
			input wordT data);
		memReqT req;
		req.read = rd;
		req.write = wr;
		req.addr = addr;
		req.wData = data;
		return req;
	endfunction

	// Field layout op[15:11] imm[10:6] rs2[8:6] rs1[5:3] rd[2:0]
	function automatic wordT encReg(input opcodeT op, input regAddrT rd, input regAddrT rs1,
			input regAddrT rs2);
		return {op, 2'b00, rs2, rs1, rd};
	endfunction

	function automatic wordT encImm(input opcodeT op, input regAddrT rd, input regAddrT rs1,
			input immT imm);
		return {op, imm, rs1, rd};
	endfunction

	task automatic emit(input wordT w);
		prog.push_back(w);
	endtask

	task automatic loadConst(input regAddrT rd, input int k);
		emit(encImm(opLdw, rd, 3'd0, immT'(16 + k)));
	endtask

	// Offset equals the data register so the word lands at r7 plus rs
	task automatic storeReg(input regAddrT rs);
		emit(encImm(opStw, 3'd0, 3'd7, {2'b00, rs}));
	endtask

	task automatic expectWrite(input wordT addr, input wordT data);
		expWrites.push_back(makeReq(1'b0, 1'b1, addr, data));
	endtask

	task automatic newProgram();
		prog.delete();
		expWrites.delete();
		for (int k = 0; k < 16; k++) begin
			consts[k] = '0;
		end
		consts[15] = storeBase;
	endtask

	task automatic loadMemory(input wordT base);
		for (int a = 0; a < 256; a++) begin
			mem[a] = wordT'(16'hFF00 | a);
		end
		for (int k = 0; k < 16; k++) begin
			mem[240 + k] = consts[k];
		end
		foreach (prog[i]) begin
			mem[base[7:0] + i] = prog[i];
		end
	endtask

	task automatic runProgram(input bit high);
		wordT start;
		int cycles;
		start = high ? highBase : 16'h0000;
		writes.delete();
		@(negedge Clock);
		rstN = 1'b0;
		rstHighN = 1'b0;
		repeat (16) begin
			@(negedge Clock);
			compareBit(high ? reqHigh.read : reqLow.read, 1'b0, "read in reset");
			compareBit(high ? reqHigh.write : reqLow.write, 1'b0, "write in reset");
			compareBit(high ? haltedHigh : haltedLow, 1'b0, "halted in reset");
		end
		if (high) begin
			rstHighN = 1'b1;
		end else begin
			rstN = 1'b1;
		end
		// Fetch read in the first cycle after release
		@(negedge Clock);
		compareReq(high ? reqHigh : reqLow, makeReq(1'b1, 1'b0, start, 16'h0000),
			"first request");
		compareBit(high ? haltedHigh : haltedLow, 1'b0, "halted after reset");
		cycles = 0;
		while ((high ? haltedHigh : haltedLow) !== 1'b1) begin
			@(negedge Clock);
			cycles++;
			if (cycles > haltLimit) begin
				$display("Timeout: the CPU did not halt within %0d cycles", haltLimit);
				$display("Errors found");
				$fatal(1, "halt wait expired");
			end
		end
	endtask

	task automatic runTest(input bit high);
		runProgram(high);
		compareWord(wordT'(writes.size()), wordT'(expWrites.size()), "number of memory writes");
		foreach (expWrites[i]) begin
			compareReq(writes[i], expWrites[i], $sformatf("memory write %0d", i));
		end
	endtask

	task automatic testAluOps(input int rounds);
		wordT a;
		wordT b;
		for (int n = 0; n < rounds; n++) begin
			a = wordT'($urandom);
			b = wordT'($urandom);
			newProgram();
			consts[0] = a;
			consts[1] = b;
			loadConst(3'd1, 0);
			loadConst(3'd2, 1);
			loadConst(3'd7, 15);
			emit(encReg(opAdd, 3'd3, 3'd1, 3'd2));
			storeReg(3'd3);
			expectWrite(storeBase + 16'd3, a + b);
			emit(encReg(opSub, 3'd4, 3'd1, 3'd2));
			storeReg(3'd4);
			expectWrite(storeBase + 16'd4, a - b);
			emit(encReg(opAnd, 3'd5, 3'd1, 3'd2));
			storeReg(3'd5);
			expectWrite(storeBase + 16'd5, a & b);
			emit(encReg(opOr, 3'd6, 3'd1, 3'd2));
			storeReg(3'd6);
			expectWrite(storeBase + 16'd6, a | b);
			// Last op may overwrite an operand
			emit(encReg(opXor, 3'd1, 3'd1, 3'd2));
			storeReg(3'd1);
			expectWrite(storeBase + 16'd1, a ^ b);
			emit(encReg(opHalt, 3'd0, 3'd0, 3'd0));
			loadMemory(16'h0000);
			runTest(1'b0);
		end
	endtask

	task automatic testAddi();
		wordT v;
		v = wordT'($urandom);
		newProgram();
		consts[0] = v;
		loadConst(3'd1, 0);
		loadConst(3'd7, 15);
		emit(encImm(opAddi, 3'd2, 3'd1, 5'b01111));
		storeReg(3'd2);
		expectWrite(storeBase + 16'd2, v + 16'd15);
		// Immediate 5'b10000 is minus 16
		emit(encImm(opAddi, 3'd3, 3'd1, 5'b10000));
		storeReg(3'd3);
		expectWrite(storeBase + 16'd3, v - 16'd16);
		emit(encReg(opHalt, 3'd0, 3'd0, 3'd0));
		loadMemory(16'h0000);
		runTest(1'b0);
	endtask

	task automatic testLoadStore(input bit high);
		wordT d;
		d = wordT'($urandom);
		newProgram();
		consts[0] = 16'h00E0;
		// Store offset of 1 puts the base one below the target
		consts[1] = 16'h00D3;
		loadConst(3'd2, 0);
		loadConst(3'd3, 1);
		emit(encImm(opLdw, 3'd1, 3'd2, 5'd0));
		emit(encImm(opStw, 3'd0, 3'd3, 5'd1));
		emit(encReg(opHalt, 3'd0, 3'd0, 3'd0));
		expectWrite(16'h00D4, d);
		loadMemory(high ? highBase : 16'h0000);
		mem[8'hE0] = d;
		runTest(high);
	endtask

	task automatic testBeq(input bit equal);
		wordT a;
		wordT b;
		a = wordT'($urandom);
		b = equal ? a : a ^ (16'h0001 | wordT'($urandom));
		newProgram();
		consts[0] = a;
		consts[1] = b;
		loadConst(3'd1, 0);
		loadConst(3'd2, 1);
		loadConst(3'd7, 15);
		emit(encReg(opSub, 3'd3, 3'd1, 3'd2));
		// Target skips the marker store
		emit(encImm(opBeq, 3'd0, 3'd0, 5'd1));
		storeReg(3'd1);
		storeReg(3'd2);
		emit(encReg(opHalt, 3'd0, 3'd0, 3'd0));
		if (!equal) begin
			expectWrite(storeBase + 16'd1, a);
		end
		expectWrite(storeBase + 16'd2, b);
		loadMemory(16'h0000);
		runTest(1'b0);
	endtask

	task automatic testJalRet(input bit high);
		wordT start;
		wordT a;
		wordT b;
		start = high ? highBase : 16'h0000;
		a = wordT'($urandom);
		b = wordT'($urandom);
		newProgram();
		consts[0] = a;
		consts[1] = b;
		loadConst(3'd7, 15);
		loadConst(3'd1, 0);
		loadConst(3'd2, 1);
		// Call at offset 3 and subroutine at offset 8
		emit(encImm(opJal, 3'd0, 3'd0, 5'd4));
		storeReg(3'd2);
		emit(encReg(opHalt, 3'd0, 3'd0, 3'd0));
		emit(encReg(opHalt, 3'd0, 3'd0, 3'd0));
		emit(encReg(opHalt, 3'd0, 3'd0, 3'd0));
		storeReg(3'd1);
		emit(encReg(opRet, 3'd0, 3'd0, 3'd0));
		expectWrite(storeBase + 16'd1, a);
		expectWrite(storeBase + 16'd2, b);
		loadMemory(start);
		runTest(high);
		compareWord(high ? dutHigh_i.datapathI.lr : dut_i.datapathI.lr, start + 16'd4,
			"link register");
	endtask

	initial begin
		rstN = 1'b0;
		rstHighN = 1'b0;
		seed = $urandom(32'h0d76904b);
		newProgram();
		loadMemory(16'h0000);
		testAluOps(4);
		testAddi();
		testLoadStore(1'b0);
		testLoadStore(1'b1);
		testBeq(1'b1);
		testBeq(1'b0);
		testJalRet(1'b0);
		testJalRet(1'b1);
		$display("No errors");
		$finish;
	end

endmodule

// ==== cpuTop.sv ====
`timescale 1ns/1ns

module cpuTop #(
	parameter cpuPkg::wordT resetPc = 16'h0000
) (
	input  logic           Clock,
	input  logic           rstN,
	input  cpuPkg::wordT   memRData,
	output cpuPkg::memReqT memReq,
	output logic           halted
);
	import cpuPkg::*;

	ctrlT ctrl;
	opcodeT opcode;
	flagsT flags;
	wordT memAddr;
	wordT memWData;
	logic memRead;
	logic memWrite;

	controller controllerI (
		.Clock    (Clock),
		.rstN     (rstN),
		.opcode   (opcode),
		.flags    (flags),
		.ctrl     (ctrl),
		.memRead  (memRead),
		.memWrite (memWrite),
		.halted   (halted)
	);

	datapath #(
		.resetPc (resetPc)
	) datapathI (
		.Clock    (Clock),
		.rstN     (rstN),
		.ctrl     (ctrl),
		.memRData (memRData),
		.opcode   (opcode),
		.flags    (flags),
		.memAddr  (memAddr),
		.memWData (memWData)
	);

	// Strobes from the controller, address and data from the datapath
	assign memReq = '{read: memRead, write: memWrite, addr: memAddr, wData: memWData};

endmodule

// ==== controller.sv ====
`timescale 1ns/1ns

module controller (
	input  logic           Clock,
	input  logic           rstN,
	input  cpuPkg::opcodeT opcode,
	input  cpuPkg::flagsT  flags,
	output cpuPkg::ctrlT   ctrl,
	output logic           memRead,
	output logic           memWrite,
	output logic           halted
);
	import cpuPkg::*;

	stateT state;
	stateT nextState;
	ctrlT nextCtrl;
	logic nextRead;
	logic nextWrite;

	// Register instruction to ALU operation
	function automatic aluOpT aluOpFor(opcodeT op);
		case (op)
			opSub:   return aluSub;
			opAnd:   return aluAnd;
			opOr:    return aluOr;
			opXor:   return aluXor;
			default: return aluAdd;
		endcase
	endfunction

	// State sequencing per opcode
	always_comb begin
		case (state)
			stFetch:  nextState = stDecode;
			stDecode: nextState = (opcode == opHalt) ? stHalted : stExecute;
			stExecute: begin
				case (opcode)
					opAdd, opSub, opAnd, opOr, opXor, opAddi: nextState = stWriteback;
					opLdw, opStw: nextState = stMemory;
					default: nextState = stFetch;
				endcase
			end
			stMemory:    nextState = (opcode == opLdw) ? stWriteback : stFetch;
			stWriteback: nextState = stFetch;
			stHalted:    nextState = stHalted;
			default:     nextState = stFetch;
		endcase
	end

	// Control word for the state about to be entered
	always_comb begin
		nextCtrl = '0;
		nextCtrl.aluOp = aluPass;
		nextCtrl.pcSel = pcInc;
		nextRead = 1'b0;
		nextWrite = 1'b0;
		case (nextState)
			stFetch: begin
				// Instruction at pc, counter steps
				nextRead = 1'b1;
				nextCtrl.irWe = 1'b1;
				nextCtrl.pcWe = 1'b1;
			end
			stDecode: begin
				// Branch target pc plus immediate, ready for execute
				nextCtrl.op1Sel = 1'b1;
				nextCtrl.op2Sel = 1'b1;
				nextCtrl.aluOp = aluAdd;
				nextCtrl.aluWe = 1'b1;
			end
			stExecute: begin
				case (opcode)
					opAdd, opSub, opAnd, opOr, opXor: begin
						nextCtrl.aluOp = aluOpFor(opcode);
						nextCtrl.aluWe = 1'b1;
						nextCtrl.flagWe = 1'b1;
					end
					opAddi: begin
						nextCtrl.op2Sel = 1'b1;
						nextCtrl.aluOp = aluAdd;
						nextCtrl.aluWe = 1'b1;
						nextCtrl.flagWe = 1'b1;
					end
					opLdw, opStw: begin
						// Address is base register plus offset
						nextCtrl.op2Sel = 1'b1;
						nextCtrl.aluOp = aluAdd;
						nextCtrl.aluWe = 1'b1;
					end
					opBeq: begin
						// Taken only on a zero result
						nextCtrl.pcWe = flags.zero;
						nextCtrl.pcSel = pcAlu;
					end
					opJal: begin
						nextCtrl.lrWe = 1'b1;
						nextCtrl.pcWe = 1'b1;
						nextCtrl.pcSel = pcAlu;
					end
					opRet: begin
						nextCtrl.pcWe = 1'b1;
						nextCtrl.pcSel = pcLr;
					end
					default: begin
						nextCtrl.aluOp = aluPass;
					end
				endcase
			end
			stMemory: begin
				// Address settles here, store goes out now
				nextCtrl.addrSel = 1'b1;
				nextWrite = (opcode == opStw);
			end
			stWriteback: begin
				nextCtrl.regWe = 1'b1;
				if (opcode == opLdw) begin
					// Load read and register write in one cycle
					nextCtrl.addrSel = 1'b1;
					nextCtrl.wdSel = 1'b1;
					nextRead = 1'b1;
				end
			end
			default: begin
				nextCtrl.aluOp = aluPass;
			end
		endcase
	end

	// Outputs registered together with the state
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			// Writeback always leads to fetch on release
			state <= stWriteback;
			ctrl <= '0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
			halted <= 1'b0;
		end else begin
			state <= nextState;
			ctrl <= nextCtrl;
			memRead <= nextRead;
			memWrite <= nextWrite;
			halted <= (nextState == stHalted);
		end
	end

endmodule

// ==== datapath.sv ====
`timescale 1ns/1ns

module datapath #(
	parameter cpuPkg::wordT resetPc = 16'h0000
) (
	input  logic           Clock,
	input  logic           rstN,
	input  cpuPkg::ctrlT   ctrl,
	input  cpuPkg::wordT   memRData,
	output cpuPkg::opcodeT opcode,
	output cpuPkg::flagsT  flags,
	output cpuPkg::wordT   memAddr,
	output cpuPkg::wordT   memWData
);
	import cpuPkg::*;

	// Architectural registers
	wordT pc;
	wordT lr;
	wordT ir;
	wordT aluOut;

	wordT rd1;
	wordT rd2;
	wordT wData;
	wordT op1;
	wordT op2;
	wordT aluRes;
	flagsT aluFlags;
	wordT pcNext;
	immT imm;
	wordT immExt;

	regBlock regBlockI (
		.Clock (Clock),
		.rstN  (rstN),
		.we    (ctrl.regWe),
		.rs1   (ir[5:3]),
		.rs2   (ir[8:6]),
		.rw    (ir[2:0]),
		.wData (wData),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	alu aluI (
		.op1    (op1),
		.op2    (op2),
		.aluOp  (ctrl.aluOp),
		.result (aluRes),
		.flags  (aluFlags)
	);

	// Sign-extended five-bit immediate
	assign imm = ir[10:6];
	assign immExt = {{11{imm[4]}}, imm};

	// Operand selection
	assign op1 = ctrl.op1Sel ? pc : rd1;
	assign op2 = ctrl.op2Sel ? immExt : rd2;

	// Register write data
	assign wData = ctrl.wdSel ? memRData : aluOut;

	// Next program counter
	always_comb begin
		case (ctrl.pcSel)
			pcInc:   pcNext = pc + 16'd1;
			pcAlu:   pcNext = aluOut;
			pcLr:    pcNext = lr;
			default: pcNext = pc + 16'd1;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			pc <= resetPc;
			lr <= '0;
			ir <= '0;
			aluOut <= '0;
			flags <= '0;
		end else begin
			if (ctrl.pcWe) begin
				pc <= pcNext;
			end
			// Counter already stepped past the call during fetch
			if (ctrl.lrWe) begin
				lr <= pc;
			end
			if (ctrl.irWe) begin
				ir <= memRData;
			end
			if (ctrl.aluWe) begin
				aluOut <= aluRes;
			end
			if (ctrl.flagWe) begin
				flags <= aluFlags;
			end
		end
	end

	// Opcode field to the controller
	assign opcode = opcodeT'(ir[15:11]);

	// Memory address and store data
	assign memAddr = ctrl.addrSel ? aluOut : pc;
	assign memWData = rd2;

endmodule

// ==== alu.sv ====
`timescale 1ns/1ns

module alu (
	input  cpuPkg::wordT  op1,
	input  cpuPkg::wordT  op2,
	input  cpuPkg::aluOpT aluOp,
	output cpuPkg::wordT  result,
	output cpuPkg::flagsT flags
);
	import cpuPkg::*;

	// 17 bits wide to keep the carry
	logic [16:0] wide;
	wordT res;
	logic carry;
	logic overflow;

	always_comb begin
		wide = '0;
		res = '0;
		carry = 1'b0;
		overflow = 1'b0;
		case (aluOp)
			aluAdd: begin
				wide = {1'b0, op1} + {1'b0, op2};
				res = wide[15:0];
				carry = wide[16];
				// Same signs in, different sign out
				overflow = (op1[15] == op2[15]) && (res[15] != op1[15]);
			end
			aluSub: begin
				wide = {1'b0, op1} - {1'b0, op2};
				res = wide[15:0];
				// Borrow out of the top bit
				carry = wide[16];
				// Different signs in, result sign flipped from op1
				overflow = (op1[15] != op2[15]) && (res[15] != op1[15]);
			end
			aluAnd: begin
				res = op1 & op2;
			end
			aluOr: begin
				res = op1 | op2;
			end
			aluXor: begin
				res = op1 ^ op2;
			end
			aluPass: begin
				res = op2;
			end
			default: begin
				res = op2;
			end
		endcase
	end

	assign result = res;

	// Zero and negative from the result
	assign flags.zero     = (res == '0);
	assign flags.negative = res[15];
	assign flags.carry    = carry;
	assign flags.overflow = overflow;

endmodule

// ==== regBlock.sv ====
`timescale 1ns/1ns

module regBlock (
	input  logic            Clock,
	input  logic            rstN,
	input  logic            we,
	input  cpuPkg::regAddrT rs1,
	input  cpuPkg::regAddrT rs2,
	input  cpuPkg::regAddrT rw,
	input  cpuPkg::wordT    wData,
	output cpuPkg::wordT    rd1,
	output cpuPkg::wordT    rd2
);
	import cpuPkg::*;

	// Eight general registers
	wordT regs [8];

	// Single write port
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rw] <= wData;
		end
	end

	// Combinational read ports
	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

	// Data word and register index
	typedef logic [15:0] wordT;
	typedef logic [2:0] regAddrT;

	// Raw immediate field, bits 10..6
	typedef logic [4:0] immT;

	// Instruction opcodes, bits 15..11
	typedef enum logic [4:0] {
		opAdd  = 5'd0,
		opSub  = 5'd1,
		opAnd  = 5'd2,
		opOr   = 5'd3,
		opXor  = 5'd4,
		opAddi = 5'd5,
		opLdw  = 5'd6,
		opStw  = 5'd7,
		opBeq  = 5'd8,
		opJal  = 5'd9,
		opRet  = 5'd10,
		opHalt = 5'd11
	} opcodeT;

	// ALU operations
	typedef enum logic [2:0] {
		aluAdd  = 3'd0,
		aluSub  = 3'd1,
		aluAnd  = 3'd2,
		aluOr   = 3'd3,
		aluXor  = 3'd4,
		// Second operand straight through
		aluPass = 3'd5
	} aluOpT;

	// Program counter sources
	typedef enum logic [1:0] {
		pcInc = 2'd0,
		pcAlu = 2'd1,
		pcLr  = 2'd2
	} pcSelT;

	// Controller states
	typedef enum logic [2:0] {
		stFetch     = 3'd0,
		stDecode    = 3'd1,
		stExecute   = 3'd2,
		stMemory    = 3'd3,
		stWriteback = 3'd4,
		stHalted    = 3'd5
	} stateT;

	// Condition flags
	typedef struct packed {
		logic zero;
		logic negative;
		logic carry;
		logic overflow;
	} flagsT;

	// One control word per cycle
	typedef struct packed {
		logic  regWe;
		// Register write data from memory
		logic  wdSel;
		// Program counter as first operand
		logic  op1Sel;
		// Immediate as second operand
		logic  op2Sel;
		aluOpT aluOp;
		logic  aluWe;
		logic  flagWe;
		logic  pcWe;
		pcSelT pcSel;
		logic  lrWe;
		logic  irWe;
		// ALU output register as memory address
		logic  addrSel;
	} ctrlT;

	// Memory request, single-cycle strobes
	typedef struct packed {
		logic read;
		logic write;
		wordT addr;
		wordT wData;
	} memReqT;

endpackage
